// File: include/aesSbox.svh
//////////////////////////////////////////////////////////////////////
// Forward S-box as a case body, included inside aesPkg::sbox
//////////////////////////////////////////////////////////////////////
`ifndef AES_SBOX_SVH
`define AES_SBOX_SVH

case (x)
  8'h00: sbox = 8'h63;  8'h01: sbox = 8'h7c;  8'h02: sbox = 8'h77;  8'h03: sbox = 8'h7b;
  8'h04: sbox = 8'hf2;  8'h05: sbox = 8'h6b;  8'h06: sbox = 8'h6f;  8'h07: sbox = 8'hc5;
  8'h08: sbox = 8'h30;  8'h09: sbox = 8'h01;  8'h0a: sbox = 8'h67;  8'h0b: sbox = 8'h2b;
  8'h0c: sbox = 8'hfe;  8'h0d: sbox = 8'hd7;  8'h0e: sbox = 8'hab;  8'h0f: sbox = 8'h76;
  8'h10: sbox = 8'hca;  8'h11: sbox = 8'h82;  8'h12: sbox = 8'hc9;  8'h13: sbox = 8'h7d;
  8'h14: sbox = 8'hfa;  8'h15: sbox = 8'h59;  8'h16: sbox = 8'h47;  8'h17: sbox = 8'hf0;
  8'h18: sbox = 8'had;  8'h19: sbox = 8'hd4;  8'h1a: sbox = 8'ha2;  8'h1b: sbox = 8'haf;
  8'h1c: sbox = 8'h9c;  8'h1d: sbox = 8'ha4;  8'h1e: sbox = 8'h72;  8'h1f: sbox = 8'hc0;
  8'h20: sbox = 8'hb7;  8'h21: sbox = 8'hfd;  8'h22: sbox = 8'h93;  8'h23: sbox = 8'h26;
  8'h24: sbox = 8'h36;  8'h25: sbox = 8'h3f;  8'h26: sbox = 8'hf7;  8'h27: sbox = 8'hcc;
  8'h28: sbox = 8'h34;  8'h29: sbox = 8'ha5;  8'h2a: sbox = 8'he5;  8'h2b: sbox = 8'hf1;
  8'h2c: sbox = 8'h71;  8'h2d: sbox = 8'hd8;  8'h2e: sbox = 8'h31;  8'h2f: sbox = 8'h15;
  8'h30: sbox = 8'h04;  8'h31: sbox = 8'hc7;  8'h32: sbox = 8'h23;  8'h33: sbox = 8'hc3;
  8'h34: sbox = 8'h18;  8'h35: sbox = 8'h96;  8'h36: sbox = 8'h05;  8'h37: sbox = 8'h9a;
  8'h38: sbox = 8'h07;  8'h39: sbox = 8'h12;  8'h3a: sbox = 8'h80;  8'h3b: sbox = 8'he2;
  8'h3c: sbox = 8'heb;  8'h3d: sbox = 8'h27;  8'h3e: sbox = 8'hb2;  8'h3f: sbox = 8'h75;
  8'h40: sbox = 8'h09;  8'h41: sbox = 8'h83;  8'h42: sbox = 8'h2c;  8'h43: sbox = 8'h1a;
  8'h44: sbox = 8'h1b;  8'h45: sbox = 8'h6e;  8'h46: sbox = 8'h5a;  8'h47: sbox = 8'ha0;
  8'h48: sbox = 8'h52;  8'h49: sbox = 8'h3b;  8'h4a: sbox = 8'hd6;  8'h4b: sbox = 8'hb3;
  8'h4c: sbox = 8'h29;  8'h4d: sbox = 8'he3;  8'h4e: sbox = 8'h2f;  8'h4f: sbox = 8'h84;
  8'h50: sbox = 8'h53;  8'h51: sbox = 8'hd1;  8'h52: sbox = 8'h00;  8'h53: sbox = 8'hed;
  8'h54: sbox = 8'h20;  8'h55: sbox = 8'hfc;  8'h56: sbox = 8'hb1;  8'h57: sbox = 8'h5b;
  8'h58: sbox = 8'h6a;  8'h59: sbox = 8'hcb;  8'h5a: sbox = 8'hbe;  8'h5b: sbox = 8'h39;
  8'h5c: sbox = 8'h4a;  8'h5d: sbox = 8'h4c;  8'h5e: sbox = 8'h58;  8'h5f: sbox = 8'hcf;
  8'h60: sbox = 8'hd0;  8'h61: sbox = 8'hef;  8'h62: sbox = 8'haa;  8'h63: sbox = 8'hfb;
  8'h64: sbox = 8'h43;  8'h65: sbox = 8'h4d;  8'h66: sbox = 8'h33;  8'h67: sbox = 8'h85;
  8'h68: sbox = 8'h45;  8'h69: sbox = 8'hf9;  8'h6a: sbox = 8'h02;  8'h6b: sbox = 8'h7f;
  8'h6c: sbox = 8'h50;  8'h6d: sbox = 8'h3c;  8'h6e: sbox = 8'h9f;  8'h6f: sbox = 8'ha8;
  8'h70: sbox = 8'h51;  8'h71: sbox = 8'ha3;  8'h72: sbox = 8'h40;  8'h73: sbox = 8'h8f;
  8'h74: sbox = 8'h92;  8'h75: sbox = 8'h9d;  8'h76: sbox = 8'h38;  8'h77: sbox = 8'hf5;
  8'h78: sbox = 8'hbc;  8'h79: sbox = 8'hb6;  8'h7a: sbox = 8'hda;  8'h7b: sbox = 8'h21;
  8'h7c: sbox = 8'h10;  8'h7d: sbox = 8'hff;  8'h7e: sbox = 8'hf3;  8'h7f: sbox = 8'hd2;
  8'h80: sbox = 8'hcd;  8'h81: sbox = 8'h0c;  8'h82: sbox = 8'h13;  8'h83: sbox = 8'hec;
  8'h84: sbox = 8'h5f;  8'h85: sbox = 8'h97;  8'h86: sbox = 8'h44;  8'h87: sbox = 8'h17;
  8'h88: sbox = 8'hc4;  8'h89: sbox = 8'ha7;  8'h8a: sbox = 8'h7e;  8'h8b: sbox = 8'h3d;
  8'h8c: sbox = 8'h64;  8'h8d: sbox = 8'h5d;  8'h8e: sbox = 8'h19;  8'h8f: sbox = 8'h73;
  8'h90: sbox = 8'h60;  8'h91: sbox = 8'h81;  8'h92: sbox = 8'h4f;  8'h93: sbox = 8'hdc;
  8'h94: sbox = 8'h22;  8'h95: sbox = 8'h2a;  8'h96: sbox = 8'h90;  8'h97: sbox = 8'h88;
  8'h98: sbox = 8'h46;  8'h99: sbox = 8'hee;  8'h9a: sbox = 8'hb8;  8'h9b: sbox = 8'h14;
  8'h9c: sbox = 8'hde;  8'h9d: sbox = 8'h5e;  8'h9e: sbox = 8'h0b;  8'h9f: sbox = 8'hdb;
  8'ha0: sbox = 8'he0;  8'ha1: sbox = 8'h32;  8'ha2: sbox = 8'h3a;  8'ha3: sbox = 8'h0a;
  8'ha4: sbox = 8'h49;  8'ha5: sbox = 8'h06;  8'ha6: sbox = 8'h24;  8'ha7: sbox = 8'h5c;
  8'ha8: sbox = 8'hc2;  8'ha9: sbox = 8'hd3;  8'haa: sbox = 8'hac;  8'hab: sbox = 8'h62;
  8'hac: sbox = 8'h91;  8'had: sbox = 8'h95;  8'hae: sbox = 8'he4;  8'haf: sbox = 8'h79;
  8'hb0: sbox = 8'he7;  8'hb1: sbox = 8'hc8;  8'hb2: sbox = 8'h37;  8'hb3: sbox = 8'h6d;
  8'hb4: sbox = 8'h8d;  8'hb5: sbox = 8'hd5;  8'hb6: sbox = 8'h4e;  8'hb7: sbox = 8'ha9;
  8'hb8: sbox = 8'h6c;  8'hb9: sbox = 8'h56;  8'hba: sbox = 8'hf4;  8'hbb: sbox = 8'hea;
  8'hbc: sbox = 8'h65;  8'hbd: sbox = 8'h7a;  8'hbe: sbox = 8'hae;  8'hbf: sbox = 8'h08;
  8'hc0: sbox = 8'hba;  8'hc1: sbox = 8'h78;  8'hc2: sbox = 8'h25;  8'hc3: sbox = 8'h2e;
  8'hc4: sbox = 8'h1c;  8'hc5: sbox = 8'ha6;  8'hc6: sbox = 8'hb4;  8'hc7: sbox = 8'hc6;
  8'hc8: sbox = 8'he8;  8'hc9: sbox = 8'hdd;  8'hca: sbox = 8'h74;  8'hcb: sbox = 8'h1f;
  8'hcc: sbox = 8'h4b;  8'hcd: sbox = 8'hbd;  8'hce: sbox = 8'h8b;  8'hcf: sbox = 8'h8a;
  8'hd0: sbox = 8'h70;  8'hd1: sbox = 8'h3e;  8'hd2: sbox = 8'hb5;  8'hd3: sbox = 8'h66;
  8'hd4: sbox = 8'h48;  8'hd5: sbox = 8'h03;  8'hd6: sbox = 8'hf6;  8'hd7: sbox = 8'h0e;
  8'hd8: sbox = 8'h61;  8'hd9: sbox = 8'h35;  8'hda: sbox = 8'h57;  8'hdb: sbox = 8'hb9;
  8'hdc: sbox = 8'h86;  8'hdd: sbox = 8'hc1;  8'hde: sbox = 8'h1d;  8'hdf: sbox = 8'h9e;
  8'he0: sbox = 8'he1;  8'he1: sbox = 8'hf8;  8'he2: sbox = 8'h98;  8'he3: sbox = 8'h11;
  8'he4: sbox = 8'h69;  8'he5: sbox = 8'hd9;  8'he6: sbox = 8'h8e;  8'he7: sbox = 8'h94;
  8'he8: sbox = 8'h9b;  8'he9: sbox = 8'h1e;  8'hea: sbox = 8'h87;  8'heb: sbox = 8'he9;
  8'hec: sbox = 8'hce;  8'hed: sbox = 8'h55;  8'hee: sbox = 8'h28;  8'hef: sbox = 8'hdf;
  8'hf0: sbox = 8'h8c;  8'hf1: sbox = 8'ha1;  8'hf2: sbox = 8'h89;  8'hf3: sbox = 8'h0d;
  8'hf4: sbox = 8'hbf;  8'hf5: sbox = 8'he6;  8'hf6: sbox = 8'h42;  8'hf7: sbox = 8'h68;
  8'hf8: sbox = 8'h41;  8'hf9: sbox = 8'h99;  8'hfa: sbox = 8'h2d;  8'hfb: sbox = 8'h0f;
  8'hfc: sbox = 8'hb0;  8'hfd: sbox = 8'h54;  8'hfe: sbox = 8'hbb;  8'hff: sbox = 8'h16;
endcase

`endif

// File: source/aesPkg.sv
//////////////////////////////////////////////////////////////////////
// Shared types, round count and byte tables for the AES-128 core
//////////////////////////////////////////////////////////////////////
`default_nettype none

package aesPkg;

  typedef logic [127:0] blockT;  // Byte 0 in bits 127:120
  typedef logic [31:0]  wordT;
  typedef logic [7:0]   byteT;
  typedef logic [3:0]   roundIdxT;

  localparam int NumRounds = 10;

  typedef enum logic {
    Idle,
    Busy
  } ctrlStateE;

  // Forward S-box lookup
  function automatic byteT sbox(input byteT x);
    `include "aesSbox.svh"
  endfunction

  // Round constant for the key schedule, zero outside rounds 1..10
  function automatic byteT rcon(input roundIdxT idx);
    case (idx)
      4'd1:    return 8'h01;
      4'd2:    return 8'h02;
      4'd3:    return 8'h04;
      4'd4:    return 8'h08;
      4'd5:    return 8'h10;
      4'd6:    return 8'h20;
      4'd7:    return 8'h40;
      4'd8:    return 8'h80;
      4'd9:    return 8'h1b;
      4'd10:   return 8'h36;
      default: return 8'h00;
    endcase
  endfunction

endpackage

`default_nettype wire

// File: source/cipherCtrlIf.sv
//////////////////////////////////////////////////////////////////////
// Round control from the controller to datapath and key expander
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

interface cipherCtrlIf;

  logic             loadKey;    // Key accepted this cycle
  logic             loadData;   // Block start accepted this cycle
  logic             step;       // Round computed this cycle
  logic             lastRound;  // Current round is round ten
  aesPkg::roundIdxT roundIdx;

  modport ctrl  (output loadKey, loadData, step, lastRound, roundIdx);
  modport round (input loadData, step, lastRound);
  modport key   (input loadKey, loadData, step, lastRound, roundIdx);

endinterface

`default_nettype wire

// File: source/aesControl.sv
//////////////////////////////////////////////////////////////////////
// Key/data handshake, idle/busy FSM, round counter and result flag
// Strobes sent on the interface already carry the enable
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module aesControl (
  input  logic        CLK,
  input  logic        RSTn,
  input  logic        en,
  input  logic        keyRdy,
  input  logic        dataRdy,
  output logic        busy,
  output logic        dataVld,
  cipherCtrlIf.ctrl   ctrl
);

  aesPkg::ctrlStateE state;
  aesPkg::roundIdxT  roundIdx;  // 0 while idle, 1..10 while busy

  logic loadKey;
  logic loadData;
  logic step;
  logic lastRound;

  assign busy = (state == aesPkg::Busy);

  // Key wins over data, both ignored while busy
  assign loadKey   = en && !busy && keyRdy;
  assign loadData  = en && !busy && !keyRdy && dataRdy;
  assign step      = en && busy;
  assign lastRound = (roundIdx == aesPkg::roundIdxT'(aesPkg::NumRounds));

  assign ctrl.loadKey   = loadKey;
  assign ctrl.loadData  = loadData;
  assign ctrl.step      = step;
  assign ctrl.lastRound = lastRound;
  assign ctrl.roundIdx  = roundIdx;

  ////////////////////////////////////////////////////////////////////
  // State, round counter and output-valid flag
  ////////////////////////////////////////////////////////////////////
  always_ff @(posedge CLK) begin
    if (!RSTn) begin
      state    <= aesPkg::Idle;
      roundIdx <= '0;
      dataVld  <= 1'b0;
    end else if (loadKey) begin
      dataVld <= 1'b0;
    end else if (loadData) begin
      state    <= aesPkg::Busy;
      roundIdx <= aesPkg::roundIdxT'(1);
      dataVld  <= 1'b0;
    end else if (step) begin
      if (lastRound) begin
        state    <= aesPkg::Idle;  // Result sits in the state register now
        roundIdx <= '0;
        dataVld  <= 1'b1;
      end else begin
        roundIdx <= roundIdx + aesPkg::roundIdxT'(1);
      end
    end
  end

  // Counter parked at zero while idle
  assert property (@(posedge CLK) disable iff (!RSTn)
    (state == aesPkg::Idle) |-> (roundIdx == '0));

  assert property (@(posedge CLK) disable iff (!RSTn)
    (state == aesPkg::Busy) |->
      (roundIdx >= 4'd1 && roundIdx <= aesPkg::roundIdxT'(aesPkg::NumRounds)));

  // A fresh result is never flagged while rounds are still running
  assert property (@(posedge CLK) disable iff (!RSTn) dataVld |-> !busy);

endmodule

`default_nettype wire

// File: source/aesKeyExpand.sv
//////////////////////////////////////////////////////////////////////
// AES-128 forward key schedule, one round key per step
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module aesKeyExpand (
  input  logic          CLK,
  cipherCtrlIf.key      ctrl,
  input  aesPkg::blockT keyIn,
  output aesPkg::blockT roundKey,
  output aesPkg::blockT masterKey
);

  aesPkg::blockT    masterReg;
  aesPkg::blockT    workKey;
  aesPkg::blockT    nextKey;
  aesPkg::wordT     rotSub;
  aesPkg::roundIdxT rconIdx;

  // Counter is 0 at load time, so the key being built is always idx+1
  assign rconIdx = ctrl.roundIdx + aesPkg::roundIdxT'(1);

  ////////////////////////////////////////////////////////////////////
  // Next round key from the working key
  ////////////////////////////////////////////////////////////////////
  always_comb begin
    // RotWord then SubWord on the last column
    rotSub = {aesPkg::sbox(workKey[23:16]), aesPkg::sbox(workKey[15:8]),
              aesPkg::sbox(workKey[7:0]),   aesPkg::sbox(workKey[31:24])};
    rotSub[31:24] = rotSub[31:24] ^ aesPkg::rcon(rconIdx);

    nextKey[127:96] = workKey[127:96] ^ rotSub;
    nextKey[95:64]  = workKey[95:64]  ^ nextKey[127:96];
    nextKey[63:32]  = workKey[63:32]  ^ nextKey[95:64];
    nextKey[31:0]   = workKey[31:0]   ^ nextKey[63:32];
  end

  always_ff @(posedge CLK) begin
    if (ctrl.loadKey) begin
      masterReg <= keyIn;
      workKey   <= keyIn;
    end else if (ctrl.loadData) begin
      workKey <= nextKey;               // Round-1 key
    end else if (ctrl.step) begin
      if (ctrl.lastRound)
        workKey <= masterReg;           // Ready for the next block
      else
        workKey <= nextKey;
    end
  end

  assign roundKey  = workKey;
  assign masterKey = masterReg;

endmodule

`default_nettype wire

// File: source/aesRound.sv
//////////////////////////////////////////////////////////////////////
// AES state register and one full encryption round per step
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module aesRound (
  input  logic          CLK,
  cipherCtrlIf.round    ctrl,
  input  aesPkg::blockT dataIn,
  input  aesPkg::blockT roundKey,
  input  aesPkg::blockT masterKey,
  output aesPkg::blockT dataOut
);

  aesPkg::blockT state;
  aesPkg::blockT subbed;
  aesPkg::blockT shifted;
  aesPkg::blockT mixed;
  aesPkg::blockT roundOut;

  // Multiply by x in GF(2^8)
  function automatic aesPkg::byteT xtime(input aesPkg::byteT b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
  endfunction

  function automatic aesPkg::wordT mixColumn(input aesPkg::wordT col);
    aesPkg::byteT a0;
    aesPkg::byteT a1;
    aesPkg::byteT a2;
    aesPkg::byteT a3;
    a0 = col[31:24];
    a1 = col[23:16];
    a2 = col[15:8];
    a3 = col[7:0];
    return {xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
            a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
            a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
            xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)};
  endfunction

  ////////////////////////////////////////////////////////////////////
  // SubBytes, ShiftRows, MixColumns
  ////////////////////////////////////////////////////////////////////
  always_comb begin
    for (int i = 0; i < 16; i++)
      subbed[127-8*i -: 8] = aesPkg::sbox(state[127-8*i -: 8]);

    // Row r of column c comes from column c+r
    for (int c = 0; c < 4; c++)
      for (int r = 0; r < 4; r++)
        shifted[127-8*(4*c+r) -: 8] = subbed[127-8*(4*((c+r)%4)+r) -: 8];

    for (int c = 0; c < 4; c++)
      mixed[127-32*c -: 32] = mixColumn(shifted[127-32*c -: 32]);
  end

  assign roundOut = ctrl.lastRound ? shifted : mixed;  // No MixColumns in round ten

  always_ff @(posedge CLK) begin
    if (ctrl.loadData)
      state <= dataIn ^ masterKey;   // Initial AddRoundKey
    else if (ctrl.step)
      state <= roundOut ^ roundKey;
  end

  assign dataOut = state;

  assert property (@(posedge CLK) ctrl.loadData |-> !ctrl.step);

endmodule

`default_nettype wire

// File: source/aesCipher.sv
//////////////////////////////////////////////////////////////////////
// Iterative AES-128 encryption core, top level with plain ports
// Load a key with keyRdy, then start blocks with dataRdy
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module aesCipher (
  input  logic         CLK,
  input  logic         RSTn,
  input  logic         en,
  input  logic         keyRdy,
  input  logic         dataRdy,
  input  logic [127:0] keyIn,
  input  logic [127:0] dataIn,
  output logic [127:0] dataOut,
  output logic         busy,
  output logic         dataVld
);

  aesPkg::blockT roundKey;
  aesPkg::blockT masterKey;

  cipherCtrlIf ctrlIf ();

  aesControl uControl (
    .CLK     (CLK),
    .RSTn    (RSTn),
    .en      (en),
    .keyRdy  (keyRdy),
    .dataRdy (dataRdy),
    .busy    (busy),
    .dataVld (dataVld),
    .ctrl    (ctrlIf.ctrl)
  );

  aesKeyExpand uKeyExpand (
    .CLK       (CLK),
    .ctrl      (ctrlIf.key),
    .keyIn     (keyIn),
    .roundKey  (roundKey),
    .masterKey (masterKey)
  );

  aesRound uRound (
    .CLK       (CLK),
    .ctrl      (ctrlIf.round),
    .dataIn    (dataIn),
    .roundKey  (roundKey),
    .masterKey (masterKey),
    .dataOut   (dataOut)
  );

endmodule

`default_nettype wire

// File: testbench/aesCipherTb.sv
//////////////////////////////////////////////////////////////////////
// Directed known-answer tests for the iterative AES-128 core
// Covers the handshake, key reuse, busy-time strobes and enable stalls
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module aesCipherTb;

  localparam int MaxCycles   = 400;  // Several times the full test length
  localparam int BlockCycles = 10;   // Edges from load to result at full enable

  localparam logic [127:0] Key1 = 128'h000102030405060708090a0b0c0d0e0f;
  localparam logic [127:0] Pt1  = 128'h00112233445566778899aabbccddeeff;
  localparam logic [127:0] Ct1  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
  localparam logic [127:0] Key2 = 128'h2b7e151628aed2a6abf7158809cf4f3c;
  localparam logic [127:0] Pt2  = 128'h3243f6a8885a308d313198a2e0370734;
  localparam logic [127:0] Ct2  = 128'h3925841d02dc09fbdc118597196a0b32;
  localparam logic [127:0] Ct0  = 128'h66e94bd4ef8a2c3b884cfa59ca342b2e;

  logic         CLK;
  logic         RSTn;
  logic         en;
  logic         keyRdy;
  logic         dataRdy;
  logic [127:0] keyIn;
  logic [127:0] dataIn;
  logic [127:0] dataOut;
  logic         busy;
  logic         dataVld;
  int           cycles;

  aesCipher dut_i (
    .CLK     (CLK),
    .RSTn    (RSTn),
    .en      (en),
    .keyRdy  (keyRdy),
    .dataRdy (dataRdy),
    .keyIn   (keyIn),
    .dataIn  (dataIn),
    .dataOut (dataOut),
    .busy    (busy),
    .dataVld (dataVld)
  );

  always #20 CLK = ~CLK;

  // Run limit
  always @(posedge CLK) begin
    cycles = cycles + 1;
    if (cycles > MaxCycles) begin
      $display("Run did not finish within %0d clock cycles", MaxCycles);
      $display("Simulation failed");
      $fatal(1, "Timeout");
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////
  task automatic checkValue(input string name, input logic [127:0] expected,
                            input logic [127:0] actual);
    assert (actual === expected) else begin
      $display("FAIL time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
      $display("Simulation failed");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  // Outputs are settled here, and inputs change here too
  task automatic nextEdge();
    @(posedge CLK);
    #5;
  endtask

  task automatic loadKey(input logic [127:0] key);
    keyIn  = key;
    keyRdy = 1'b1;
    nextEdge();
    keyRdy = 1'b0;
    checkValue("dataVld", 1'b0, dataVld);  // Cleared by the accepted key
  endtask

  // Returns just after edge 0
  task automatic startBlock(input logic [127:0] pt);
    dataIn  = pt;
    dataRdy = 1'b1;
    nextEdge();
    dataRdy = 1'b0;
    checkValue("busy", 1'b1, busy);
    checkValue("dataVld", 1'b0, dataVld);
  endtask

  // Counts edges from edge 0, en low after edge stallAt for stallLen cycles
  task automatic finishBlock(input logic [127:0] ct, input int stallAt, input int stallLen);
    int total;
    total = BlockCycles + stallLen;
    for (int n = 1; n <= total; n++) begin
      nextEdge();
      if (n < total) begin
        checkValue("busy", 1'b1, busy);
        checkValue("dataVld", 1'b0, dataVld);
      end else begin
        checkValue("busy", 1'b0, busy);
        checkValue("dataVld", 1'b1, dataVld);
        checkValue("dataOut", ct, dataOut);
      end
      if (n == stallAt)
        en = 1'b0;
      if (n == stallAt + stallLen)
        en = 1'b1;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////
  task automatic testReset();
    checkValue("busy", 1'b0, busy);
    checkValue("dataVld", 1'b0, dataVld);
  endtask

  task automatic testFirstVector();
    loadKey(Key1);
    startBlock(Pt1);
    finishBlock(Ct1, 0, 0);
  endtask

  // Same key twice shows the master key comes back after a block
  task automatic testKeyReuse();
    startBlock(Pt1);
    finishBlock(Ct1, 0, 0);
    loadKey(Key2);
    startBlock(Pt2);
    finishBlock(Ct2, 0, 0);
  endtask

  task automatic testBusyIgnore();
    startBlock(Pt2);
    dataIn  = Pt1;
    keyIn   = Key1;
    dataRdy = 1'b1;  // Held through every busy edge
    keyRdy  = 1'b1;
    finishBlock(Ct2, 0, 0);
    dataRdy = 1'b0;
    keyRdy  = 1'b0;
    startBlock(Pt2);  // Still under the second key
    finishBlock(Ct2, 0, 0);
  endtask

  task automatic testEnableStall();
    loadKey('0);
    startBlock('0);
    finishBlock(Ct0, 4, 5);
  endtask

  task automatic testResultHold();
    repeat (3) begin
      nextEdge();
      checkValue("busy", 1'b0, busy);
      checkValue("dataVld", 1'b1, dataVld);
      checkValue("dataOut", Ct0, dataOut);
    end
    loadKey(Key1);
    checkValue("dataOut", Ct0, dataOut);  // Key load leaves the state alone
    nextEdge();
    checkValue("dataVld", 1'b0, dataVld);
  endtask

  initial begin
    CLK     = 1'b0;
    RSTn    = 1'b0;
    en      = 1'b0;  // Keeps the strobes known during reset
    keyRdy  = 1'b0;
    dataRdy = 1'b0;
    keyIn   = '0;
    dataIn  = '0;
    cycles  = 0;
    repeat (16) @(posedge CLK);
    #5;
    RSTn = 1'b1;
    en   = 1'b1;

    testReset();
    testFirstVector();
    testKeyReuse();
    testBusyIgnore();
    testEnableStall();
    testResultHold();

    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+include
source/aesPkg.sv
source/cipherCtrlIf.sv
source/aesControl.sv
source/aesKeyExpand.sv
source/aesRound.sv
source/aesCipher.sv
testbench/aesCipherTb.sv

// File: Bender.yml
package:
  name: aesCipher

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/aesPkg.sv
      - source/cipherCtrlIf.sv
      - source/aesControl.sv
      - source/aesKeyExpand.sv
      - source/aesRound.sv
      - source/aesCipher.sv
  - target: test
    files:
      - testbench/aesCipherTb.sv
